//--- design/fsab_mem_pkg.sv
package fsab_mem_pkg;

	localparam int DATA_W     = 32;	// One bus beat
	localparam int MASK_W     = 4;
	localparam int WORD_W     = 64;	// Two beats per memory word
	localparam int WMASK_W    = 8;
	localparam int ADDR_W     = 32;	// Byte address
	localparam int DID_W      = 4;
	localparam int LEN_W      = 4;
	localparam int WORD_BYTES = 8;

	// Request kind on the host bus
	typedef enum logic {
		FSAB_READ,
		FSAB_WRITE
	} fsab_mode_e;

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_cmd_e;

	// Width of a counter that must hold 0..n
	function automatic int cnt_w(input int n);
		return $clog2(n + 1);
	endfunction

	function automatic int idx_w(input int n);
		return (n > 1) ? $clog2(n) : 1;	// Index into n entries
	endfunction

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo import fsab_mem_pkg::*; #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic                      clk0_tb,
	input  logic                      rst0_tb,
	input  logic                      push,
	input  logic [WIDTH-1:0]          wdata,
	input  logic                      pop,
	output logic [WIDTH-1:0]          rdata,
	output logic                      empty,
	output logic [cnt_w(DEPTH)-1:0]   count
);
	localparam int PW = idx_w(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]    wptr;
	logic [PW-1:0]    rptr;

	function automatic logic [PW-1:0] bump(input logic [PW-1:0] p);
		return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;	// Wrap at DEPTH
	endfunction

	assign empty = (count == '0);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (push) wptr <= bump(wptr);
			if (pop) rptr <= bump(rptr);
			if (push && !pop) count <= count + 1'b1;
			else if (pop && !push) count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (push) mem[wptr] <= wdata;
		if (pop) rdata <= mem[rptr];	// Valid the cycle after pop
	end

endmodule

//--- design/fsab_inbound.sv
`timescale 1ns/100ps

module fsab_inbound import fsab_mem_pkg::*; #(
	parameter int CREDITS = 4,
	parameter int LEN_MAX = 8
) (
	input  logic               clk0_tb,
	input  logic               rst0_tb,
	input  logic               fsabo_valid,
	input  fsab_mode_e         fsabo_mode,
	input  logic [DID_W-1:0]   fsabo_did,
	input  logic [DID_W-1:0]   fsabo_subdid,
	input  logic [ADDR_W-1:0]  fsabo_addr,
	input  logic [LEN_W-1:0]   fsabo_len,
	input  logic [DATA_W-1:0]  fsabo_data,
	input  logic [MASK_W-1:0]  fsabo_mask,
	input  logic               req_take,
	input  logic               word_take,
	output logic               req_avail,
	output fsab_mode_e         req_mode,
	output logic [DID_W-1:0]   req_did,
	output logic [DID_W-1:0]   req_subdid,
	output logic [ADDR_W-1:0]  req_addr,
	output logic [LEN_W-1:0]   req_len,
	output logic [WORD_W-1:0]  word_data,
	output logic [WMASK_W-1:0] word_mask
);
	localparam int HW  = 1 + 2 * DID_W + ADDR_W + LEN_W;
	localparam int WQW = WORD_W + WMASK_W;
	localparam int QW  = cnt_w(CREDITS);

	logic [LEN_W-1:0]  beats_left;	// Data beats still due for current write
	logic              is_hdr;
	logic              wr_beat;
	logic              have_lo;
	logic              word_push;
	logic              req_done;
	logic [DATA_W-1:0] prev_data;
	logic [MASK_W-1:0] prev_mask;
	logic [HW-1:0]     hdr_rdata;
	logic [WQW-1:0]    word_rdata;
	logic [QW-1:0]     req_cnt;	// Requests fully queued

	assign is_hdr    = fsabo_valid && (beats_left == '0);
	assign wr_beat   = (is_hdr && fsabo_mode == FSAB_WRITE) ||
	                   (fsabo_valid && beats_left != '0);
	assign word_push = wr_beat && have_lo;	// Second beat of a pair
	// A read is complete with its header, a write with its last word
	assign req_done  = (is_hdr && fsabo_mode == FSAB_READ) ||
	                   (word_push && beats_left == LEN_W'(1));
	assign req_avail = (req_cnt != '0);

	sync_fifo #(.WIDTH(HW), .DEPTH(CREDITS)) i_hdr_fifo (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.push    (is_hdr),
		.wdata   ({fsabo_mode, fsabo_did, fsabo_subdid, fsabo_addr, fsabo_len}),
		.pop     (req_take),
		.rdata   (hdr_rdata),
		.empty   (),
		.count   ()
	);

	sync_fifo #(.WIDTH(WQW), .DEPTH(CREDITS * LEN_MAX / 2)) i_word_fifo (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.push    (word_push),
		.wdata   ({fsabo_data, prev_data, fsabo_mask, prev_mask}),	// First beat low
		.pop     (word_take),
		.rdata   (word_rdata),
		.empty   (),
		.count   ()
	);

	assign req_mode = fsab_mode_e'(hdr_rdata[HW-1]);
	assign {req_did, req_subdid, req_addr, req_len} = hdr_rdata[HW-2:0];
	assign {word_data, word_mask} = word_rdata;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			beats_left <= '0;
			have_lo    <= 1'b0;
			req_cnt    <= '0;
		end else begin
			if (is_hdr && fsabo_mode == FSAB_WRITE) beats_left <= fsabo_len - 1'b1;
			else if (fsabo_valid && beats_left != '0) beats_left <= beats_left - 1'b1;
			if (wr_beat) have_lo <= !have_lo;
			if (req_done && !req_take) req_cnt <= req_cnt + 1'b1;
			else if (req_take && !req_done) req_cnt <= req_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (wr_beat && !have_lo) begin
			prev_data <= fsabo_data;	// Low half, waits for its partner
			prev_mask <= fsabo_mask;
		end
	end

endmodule

//--- design/mem_ctrl.sv
`timescale 1ns/100ps

module mem_ctrl import fsab_mem_pkg::*; #(
	parameter int RESP_SLOTS = 2,
	parameter int MEM_WORDS  = 256
) (
	input  logic                       clk0_tb,
	input  logic                       rst0_tb,
	input  logic                       req_avail,
	input  fsab_mode_e                 req_mode,
	input  logic [DID_W-1:0]           req_did,
	input  logic [DID_W-1:0]           req_subdid,
	input  logic [ADDR_W-1:0]          req_addr,
	input  logic [LEN_W-1:0]           req_len,
	input  logic [WORD_W-1:0]          word_data,
	input  logic [WMASK_W-1:0]         word_mask,
	input  logic                       resp_done,
	output logic                       req_take,
	output logic                       word_take,
	output logic                       mem_en,
	output mem_cmd_e                   mem_cmd,
	output logic [idx_w(MEM_WORDS)-1:0] mem_addr,
	output logic [WORD_W-1:0]          mem_wdata,
	output logic [WMASK_W-1:0]         mem_wmask,
	output logic                       hdr_push,
	output logic [DID_W-1:0]           hdr_did,
	output logic [DID_W-1:0]           hdr_subdid,
	output logic [LEN_W-1:0]           hdr_len,
	output logic                       fsabo_credit
);
	localparam int AW  = idx_w(MEM_WORDS);
	localparam int SW  = cnt_w(RESP_SLOTS);
	localparam int WSH = $clog2(WORD_BYTES);

	typedef enum logic [1:0] {IDLE, WRITING, READING} state_e;

	state_e           state;
	logic             take_d;	// Header visible on req_* this cycle
	logic [LEN_W-1:0] words_left;
	logic [AW-1:0]    waddr;
	logic [SW-1:0]    slots;	// Free outbound response slots
	logic             last_op;

	assign last_op = (state != IDLE) && (words_left == LEN_W'(1));

	// Mode is unknown until the pop lands, so any take needs a free slot
	assign req_take  = (state == IDLE) && !take_d && req_avail && (slots != '0);
	assign word_take = (take_d && req_mode == FSAB_WRITE) || (state == WRITING && !last_op);

	assign hdr_push   = take_d && (req_mode == FSAB_READ);
	assign hdr_did    = req_did;
	assign hdr_subdid = req_subdid;
	assign hdr_len    = req_len;

	assign mem_en       = (state != IDLE);	// One operation per active cycle
	assign mem_cmd      = (state == WRITING) ? MEM_WRITE : MEM_READ;
	assign mem_addr     = waddr;
	assign mem_wdata    = word_data;
	assign mem_wmask    = word_mask;
	assign fsabo_credit = last_op;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			state      <= IDLE;
			take_d     <= 1'b0;
			words_left <= '0;
			waddr      <= '0;
			slots      <= SW'(RESP_SLOTS);
		end else begin
			take_d <= req_take;
			if (take_d) begin
				state      <= (req_mode == FSAB_WRITE) ? WRITING : READING;
				words_left <= req_len >> 1;
				waddr      <= AW'((req_addr >> WSH) % MEM_WORDS);
			end else if (state != IDLE) begin
				words_left <= words_left - 1'b1;
				waddr      <= (waddr == AW'(MEM_WORDS - 1)) ? '0 : waddr + 1'b1;
				if (last_op) state <= IDLE;
			end
			if (hdr_push && !resp_done) slots <= slots - 1'b1;
			else if (resp_done && !hdr_push) slots <= slots + 1'b1;
		end
	end

endmodule

//--- design/burst_mem.sv
`timescale 1ns/100ps

module burst_mem import fsab_mem_pkg::*; #(
	parameter int MEM_WORDS = 256,
	parameter int RD_LAT    = 2
) (
	input  logic                        clk0_tb,
	input  logic                        rst0_tb,
	input  logic                        mem_en,
	input  mem_cmd_e                    mem_cmd,
	input  logic [idx_w(MEM_WORDS)-1:0] mem_addr,
	input  logic [WORD_W-1:0]           mem_wdata,
	input  logic [WMASK_W-1:0]          mem_wmask,
	output logic                        rd_valid,
	output logic [WORD_W-1:0]           rd_data
);
	logic [WORD_W-1:0] mem [MEM_WORDS];
	logic [RD_LAT-1:0] vpipe;
	logic [WORD_W-1:0] dpipe [RD_LAT];

	always_ff @(posedge clk0_tb) begin
		if (mem_en && mem_cmd == MEM_WRITE) begin
			for (int i = 0; i < WMASK_W; i++) begin
				if (!mem_wmask[i]) mem[mem_addr][i*8 +: 8] <= mem_wdata[i*8 +: 8];	// Set bit skips
			end
		end
		dpipe[0] <= mem[mem_addr];
		for (int s = 1; s < RD_LAT; s++) dpipe[s] <= dpipe[s-1];
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			vpipe <= '0;
		end else begin
			vpipe[0] <= mem_en && (mem_cmd == MEM_READ);
			for (int s = 1; s < RD_LAT; s++) vpipe[s] <= vpipe[s-1];
		end
	end

	assign rd_valid = vpipe[RD_LAT-1];
	assign rd_data  = dpipe[RD_LAT-1];

endmodule

//--- design/fsab_outbound.sv
`timescale 1ns/100ps

module fsab_outbound import fsab_mem_pkg::*; #(
	parameter int RESP_SLOTS = 2,
	parameter int LEN_MAX    = 8
) (
	input  logic              clk0_tb,
	input  logic              rst0_tb,
	input  logic              hdr_push,
	input  logic [DID_W-1:0]  hdr_did,
	input  logic [DID_W-1:0]  hdr_subdid,
	input  logic [LEN_W-1:0]  hdr_len,
	input  logic              rd_valid,
	input  logic [WORD_W-1:0] rd_data,
	output logic              fsabi_valid,
	output logic [DID_W-1:0]  fsabi_did,
	output logic [DID_W-1:0]  fsabi_subdid,
	output logic [DATA_W-1:0] fsabi_data,
	output logic              resp_done
);
	localparam int HW     = 2 * DID_W + LEN_W;
	localparam int WDEPTH = RESP_SLOTS * LEN_MAX / 2;
	localparam int CW     = cnt_w(WDEPTH);

	typedef enum logic [1:0] {O_IDLE, O_WAIT, O_SEND} ostate_e;

	ostate_e          state;
	logic             hdr_pop;
	logic             hdr_empty;
	logic [HW-1:0]    hdr_rdata;
	logic [LEN_W-1:0] resp_len;
	logic             word_pop;
	logic [WORD_W-1:0] word_rdata;
	logic [CW-1:0]    word_cnt;
	logic             words_ready;
	logic [LEN_W-1:0] beats_left;
	logic             hi_half;

	sync_fifo #(.WIDTH(HW), .DEPTH(RESP_SLOTS)) i_hdr_fifo (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.push    (hdr_push),
		.wdata   ({hdr_did, hdr_subdid, hdr_len}),
		.pop     (hdr_pop),
		.rdata   (hdr_rdata),
		.empty   (hdr_empty),
		.count   ()
	);

	sync_fifo #(.WIDTH(WORD_W), .DEPTH(WDEPTH)) i_word_fifo (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.push    (rd_valid),
		.wdata   (rd_data),
		.pop     (word_pop),
		.rdata   (word_rdata),
		.empty   (),
		.count   (word_cnt)
	);

	assign {fsabi_did, fsabi_subdid, resp_len} = hdr_rdata;	// Held until next header pop
	assign words_ready = (word_cnt >= CW'(resp_len >> 1));	// Whole response buffered

	assign hdr_pop  = (state == O_IDLE) && !hdr_empty;
	assign word_pop = ((state == O_WAIT) && words_ready) ||
	                  ((state == O_SEND) && hi_half && (beats_left > LEN_W'(2)));

	assign fsabi_valid = (state == O_SEND);
	assign fsabi_data  = hi_half ? word_rdata[WORD_W-1 -: DATA_W] : word_rdata[DATA_W-1:0];
	assign resp_done   = (state == O_SEND) && (beats_left == LEN_W'(1));

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			state      <= O_IDLE;
			beats_left <= '0;
			hi_half    <= 1'b0;
		end else begin
			case (state)
				O_IDLE: if (hdr_pop) state <= O_WAIT;
				O_WAIT: begin
					if (words_ready) begin
						state      <= O_SEND;
						beats_left <= resp_len;
						hi_half    <= 1'b0;
					end
				end
				O_SEND: begin
					hi_half    <= !hi_half;
					beats_left <= beats_left - 1'b1;
					if (resp_done) state <= O_IDLE;
				end
				default: state <= O_IDLE;
			endcase
		end
	end

endmodule

//--- design/fsab_mem_top.sv
`timescale 1ns/100ps

module fsab_mem_top import fsab_mem_pkg::*; #(
	parameter int CREDITS    = 4,
	parameter int LEN_MAX    = 8,
	parameter int RESP_SLOTS = 2,
	parameter int MEM_WORDS  = 256,
	parameter int RD_LAT     = 2
) (
	input  logic              clk0_tb,
	input  logic              rst0_tb,
	input  logic              fsabo_valid,
	input  fsab_mode_e        fsabo_mode,
	input  logic [DID_W-1:0]  fsabo_did,
	input  logic [DID_W-1:0]  fsabo_subdid,
	input  logic [ADDR_W-1:0] fsabo_addr,
	input  logic [LEN_W-1:0]  fsabo_len,
	input  logic [DATA_W-1:0] fsabo_data,
	input  logic [MASK_W-1:0] fsabo_mask,
	output logic              fsabo_credit,
	output logic              fsabi_valid,
	output logic [DID_W-1:0]  fsabi_did,
	output logic [DID_W-1:0]  fsabi_subdid,
	output logic [DATA_W-1:0] fsabi_data
);
	// Inbound to memory control
	logic               req_avail;
	logic               req_take;
	fsab_mode_e         req_mode;
	logic [DID_W-1:0]   req_did;
	logic [DID_W-1:0]   req_subdid;
	logic [ADDR_W-1:0]  req_addr;
	logic [LEN_W-1:0]   req_len;
	logic               word_take;
	logic [WORD_W-1:0]  word_data;
	logic [WMASK_W-1:0] word_mask;

	logic                        mem_en;
	mem_cmd_e                    mem_cmd;
	logic [idx_w(MEM_WORDS)-1:0] mem_addr;
	logic [WORD_W-1:0]           mem_wdata;
	logic [WMASK_W-1:0]          mem_wmask;
	logic                        rd_valid;
	logic [WORD_W-1:0]           rd_data;

	// Response headers and slot returns
	logic               hdr_push;
	logic [DID_W-1:0]   hdr_did;
	logic [DID_W-1:0]   hdr_subdid;
	logic [LEN_W-1:0]   hdr_len;
	logic               resp_done;

	fsab_inbound #(.CREDITS(CREDITS), .LEN_MAX(LEN_MAX)) i_fsab_inbound (.*);

	mem_ctrl #(.RESP_SLOTS(RESP_SLOTS), .MEM_WORDS(MEM_WORDS)) i_mem_ctrl (.*);

	burst_mem #(.MEM_WORDS(MEM_WORDS), .RD_LAT(RD_LAT)) i_burst_mem (.*);

	fsab_outbound #(.RESP_SLOTS(RESP_SLOTS), .LEN_MAX(LEN_MAX)) i_fsab_outbound (.*);

endmodule

//--- verif/fsab_mem_chk.sv
`timescale 1ns/100ps

module fsab_mem_chk import fsab_mem_pkg::*; (
	input logic              clk0_tb,
	input logic              rst0_tb,
	input logic              fsabo_valid,
	input fsab_mode_e        fsabo_mode,
	input logic [LEN_W-1:0]  fsabo_len,
	input logic              fsabo_credit,
	input logic              fsabi_valid,
	input logic [DID_W-1:0]  fsabi_did,
	input logic [DID_W-1:0]  fsabi_subdid
);
	logic [LEN_W-1:0] beats_left;	// Write beats still due after the header
	logic [15:0]      req_cnt;
	logic [15:0]      cred_cnt;
	logic             seen_req;
	int               fail_cnt = 0;	// Polled by the testbench

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			beats_left <= '0;
			req_cnt    <= '0;
			cred_cnt   <= '0;
			seen_req   <= 1'b0;
		end else begin
			if (fsabo_valid && beats_left == '0) begin
				req_cnt  <= req_cnt + 1'b1;
				seen_req <= 1'b1;
				if (fsabo_mode == FSAB_WRITE) beats_left <= fsabo_len - 1'b1;
			end else if (fsabo_valid) begin
				beats_left <= beats_left - 1'b1;
			end
			if (fsabo_credit) cred_cnt <= cred_cnt + 1'b1;
		end
	end

	// Bus stays quiet until the host has asked for something
	quiet_after_reset: assert property (@(posedge clk0_tb)
		!seen_req |-> !fsabo_credit && !fsabi_valid)
		else begin
			fail_cnt++;
			$error("credit or response before the first request");
		end

	credit_bound: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		cred_cnt <= req_cnt)
		else begin
			fail_cnt++;
			$error("more credits returned than requests sent");
		end

	id_stable: assert property (@(posedge clk0_tb) disable iff (rst0_tb)
		fsabi_valid && $past(fsabi_valid) |-> $stable(fsabi_did) && $stable(fsabi_subdid))
		else begin
			fail_cnt++;
			$error("did or subdid changed inside a response");
		end

endmodule

bind fsab_mem_top fsab_mem_chk i_fsab_mem_chk (
	.clk0_tb      (clk0_tb),
	.rst0_tb      (rst0_tb),
	.fsabo_valid  (fsabo_valid),
	.fsabo_mode   (fsabo_mode),
	.fsabo_len    (fsabo_len),
	.fsabo_credit (fsabo_credit),
	.fsabi_valid  (fsabi_valid),
	.fsabi_did    (fsabi_did),
	.fsabi_subdid (fsabi_subdid)
);

//--- verif/tb_fsab_mem.sv
`timescale 1ns/100ps

module tb_fsab_mem import fsab_mem_pkg::*;;
	localparam int CREDITS    = 4;
	localparam int LEN_MAX    = 8;
	localparam int RESP_SLOTS = 2;
	localparam int MEM_WORDS  = 256;
	localparam int RD_LAT     = 2;
	localparam int MEM_BYTES  = MEM_WORDS * WORD_BYTES;
	localparam int BA         = $clog2(MEM_BYTES);
	localparam int TMO        = 500;	// Cycles allowed per wait

	logic              clk0_tb;
	logic              rst0_tb;
	logic              fsabo_valid;
	fsab_mode_e        fsabo_mode;
	logic [DID_W-1:0]  fsabo_did;
	logic [DID_W-1:0]  fsabo_subdid;
	logic [ADDR_W-1:0] fsabo_addr;
	logic [LEN_W-1:0]  fsabo_len;
	logic [DATA_W-1:0] fsabo_data;
	logic [MASK_W-1:0] fsabo_mask;
	logic              fsabo_credit;
	logic              fsabi_valid;
	logic [DID_W-1:0]  fsabi_did;
	logic [DID_W-1:0]  fsabi_subdid;
	logic [DATA_W-1:0] fsabi_data;

	logic [7:0]         ref_mem [MEM_BYTES];	// Byte image of burst_mem
	logic [DATA_W-1:0]  exp_beat [$];
	logic [2*DID_W-1:0] exp_id [$];
	int                 exp_len [$];
	int                 wr_addr [$];	// Regions fully written once
	int                 wr_len [$];
	logic [DATA_W-1:0]  exp_b;
	logic [2*DID_W-1:0] exp_i;
	logic [31:0]        lcg_state = 32'hd8e9_b803;
	logic [31:0]        rnd;
	int                 sent = 0;
	int                 returned = 0;
	int                 beats_due = 0;

	fsab_mem_top #(
		.CREDITS    (CREDITS),
		.LEN_MAX    (LEN_MAX),
		.RESP_SLOTS (RESP_SLOTS),
		.MEM_WORDS  (MEM_WORDS),
		.RD_LAT     (RD_LAT)
	) i_fsab_mem_top (
		.clk0_tb      (clk0_tb),
		.rst0_tb      (rst0_tb),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	initial begin
		clk0_tb = 1'b0;
		forever #50 clk0_tb = ~clk0_tb;
	end

	task automatic stop_on_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {lcg_state[15:0], lcg_state[31:16]};	// Low LCG bits are weak
	endfunction

	function automatic logic [BA-1:0] wrap_byte(input int a);
		return BA'(a % MEM_BYTES);
	endfunction

	task automatic wait_credit();
		int tmo;
		tmo = 0;
		while (sent - returned >= CREDITS) begin
			@(posedge clk0_tb);
			#10;
			tmo++;
			if (tmo > TMO) stop_on_error("timed out waiting for a host credit");
		end
	endtask

	task automatic wait_idle();
		int tmo;
		tmo = 0;
		while (returned != sent || exp_len.size() != 0 || beats_due != 0) begin
			@(posedge clk0_tb);
			#10;
			tmo++;
			if (tmo > TMO) stop_on_error("timed out waiting for requests to finish");
		end
	endtask

	task automatic send_req(input fsab_mode_e mode, input int addr, input int len,
		input bit masked);
		logic [31:0] r;
		logic [31:0] d;
		logic [3:0]  m;
		logic [3:0]  did;
		logic [3:0]  sub;
		int          base;
		wait_credit();
		r = next_rand();
		did = r[3:0];
		sub = r[7:4];
		sent++;
		fsabo_mode   = mode;
		fsabo_did    = did;
		fsabo_subdid = sub;
		fsabo_addr   = ADDR_W'(addr);
		fsabo_len    = LEN_W'(len);
		if (mode == FSAB_READ) begin
			exp_len.push_back(len);
			for (int j = 0; j < len; j++) begin
				base = addr + 4 * j;
				exp_beat.push_back({ref_mem[wrap_byte(base + 3)], ref_mem[wrap_byte(base + 2)],
					ref_mem[wrap_byte(base + 1)], ref_mem[wrap_byte(base)]});
				exp_id.push_back({did, sub});
			end
			fsabo_valid = 1'b1;
			fsabo_data  = next_rand();	// Ignored on a read
			fsabo_mask  = '0;
			@(posedge clk0_tb);
			#10;
		end else begin
			for (int j = 0; j < len; j++) begin
				d = next_rand();
				r = next_rand();
				m = masked ? r[3:0] : 4'h0;
				fsabo_valid = 1'b1;
				fsabo_data  = d;
				fsabo_mask  = m;
				for (int b = 0; b < MASK_W; b++) begin
					if (!m[0]) ref_mem[wrap_byte(addr + 4 * j + b)] = d[7:0];
					m = m >> 1;
					d = d >> 8;
				end
				@(posedge clk0_tb);
				#10;
			end
		end
		fsabo_valid = 1'b0;
	endtask

	// Sampled mid-cycle where DUT outputs are settled
	always @(negedge clk0_tb) begin
		if (!rst0_tb) begin
			if (fsabo_credit) returned++;
			assert (returned <= sent) else stop_on_error("credit returned with nothing outstanding");
			assert (i_fsab_mem_top.i_fsab_mem_chk.fail_cnt == 0)
				else stop_on_error("port checker assertion failed");
			if (fsabi_valid) begin
				if (beats_due == 0) begin
					assert (exp_len.size() != 0) else stop_on_error("response with no read pending");
					beats_due = exp_len.pop_front();
				end
				exp_b = exp_beat.pop_front();
				exp_i = exp_id.pop_front();
				assert (fsabi_data === exp_b)
					else stop_on_error($sformatf("data %h, expected %h", fsabi_data, exp_b));
				assert ({fsabi_did, fsabi_subdid} === exp_i)
					else stop_on_error($sformatf("did/subdid %h%h, expected %h",
						fsabi_did, fsabi_subdid, exp_i));
				beats_due--;
			end else begin
				assert (beats_due == 0) else stop_on_error("gap inside a read response");
			end
		end
	end

	initial begin
		rst0_tb      = 1'b1;
		fsabo_valid  = 1'b0;
		fsabo_mode   = FSAB_READ;
		fsabo_did    = '0;
		fsabo_subdid = '0;
		fsabo_addr   = '0;
		fsabo_len    = '0;
		fsabo_data   = '0;
		fsabo_mask   = '0;
		repeat (16) @(posedge clk0_tb);
		#10;
		rst0_tb = 1'b0;
		repeat (2) @(posedge clk0_tb);
		#10;
		for (int i = 0; i < 6; i++) begin	// Plain write, then read back
			rnd = next_rand();
			wr_addr.push_back(8 * int'(rnd[15:8]));
			wr_len.push_back(2 + 2 * int'(rnd[1:0]));
			send_req(FSAB_WRITE, wr_addr[i], wr_len[i], 1'b0);
			send_req(FSAB_READ, wr_addr[i], wr_len[i], 1'b0);
		end
		for (int i = 0; i < 6; i++) begin	// Masked overwrite of known data
			send_req(FSAB_WRITE, wr_addr[i], wr_len[i], 1'b1);
			send_req(FSAB_READ, wr_addr[i], wr_len[i], 1'b0);
		end
		wait_idle();
		for (int i = 0; i < CREDITS; i++) begin	// Uses every host credit at once
			rnd = next_rand();
			wr_addr.push_back(8 * int'(rnd[15:8]));
			wr_len.push_back(LEN_MAX);
			send_req(FSAB_WRITE, wr_addr[6 + i], LEN_MAX, 1'b0);
		end
		for (int i = 0; i < 3 * RESP_SLOTS; i++) begin	// Outruns the response slots
			send_req(FSAB_READ, wr_addr[wr_addr.size() - 1 - i], wr_len[wr_len.size() - 1 - i], 1'b0);
		end
		wait_idle();
		repeat (2 * LEN_MAX) @(posedge clk0_tb);	// Quiet window for stray credits
		if (returned == sent && i_fsab_mem_top.i_fsab_mem_chk.fail_cnt == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			stop_on_error("credit count or port check wrong at end of run");
		end
	end

endmodule

//--- sources.f
design/fsab_mem_pkg.sv
design/sync_fifo.sv
design/fsab_inbound.sv
design/mem_ctrl.sv
design/burst_mem.sv
design/fsab_outbound.sv
design/fsab_mem_top.sv
verif/fsab_mem_chk.sv
verif/tb_fsab_mem.sv

//--- Makefile
TOP = tb_fsab_mem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q '^Test OK$$'

clean:
	rm -rf obj_dir
